/* fb_display.f */
hdl/video_pkg.sv
hdl/fb_pkg.sv
hdl/span_writer.sv
hdl/frame_ram.sv
hdl/scan_out.sv
hdl/fb_display.sv
tb/tb_fb_display.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fb_display
FILELIST  ?= fb_display.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_fb_display.sv */
`timescale 1ns/1ps

module tb_fb_display;

    import video_pkg::*;
    import fb_pkg::*;

    // frames * 200 plus spans * 400 cycles with a margin of two
    localparam int n_frames = 20;
    localparam int n_spans = 28;
    localparam int cycle_limit = 2 * (n_frames * 200 + n_spans * 400);

    logic        clk;
    logic        rst_n;
    span_t       span;
    logic        span_valid;
    logic        busy;
    logic        swap_req;
    video_t      video;

    pixel_t      bank_model [2][frame_pixels];
    int          front_model;
    int          mismatch_cnt;
    int          other_err_cnt;
    int          cycle_cnt;
    int          accept_cnt;
    int          spans_sent;
    logic        busy_prev;
    logic [31:0] lcg_state;

    fb_display u_fb_display (
        .clk        (clk),
        .rst_n      (rst_n),
        .span       (span),
        .span_valid (span_valid),
        .busy       (busy),
        .swap_req   (swap_req),
        .video      (video)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // each accepted span raises busy for at least one cycle
    always @(negedge clk) begin
        if (rst_n && busy && !busy_prev) accept_cnt = accept_cnt + 1;
        busy_prev = busy;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_pixel(input string name, input pixel_t act, input pixel_t exp);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("FAILED %s: got %h expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic compare_count(input string name, input int act, input int exp);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("FAILED %s: got %h expected %h at %0t", name, act, exp, $time);
        end
    endtask

    // span held until the writer takes it
    task automatic send_span(input coord_t x, input coord_t y, input pixel_t color,
                             input int len);
        int start;
        int n;
        span       = '{x: x, y: y, color: color, len: 8'(len)};
        span_valid = 1'b1;
        while (busy) tick();
        tick();
        span_valid = 1'b0;
        spans_sent++;
        if (!busy) begin
            other_err_cnt++;
            $display("busy did not rise in the cycle after a span was accepted");
        end
        start = int'(y) * h_disp + int'(x);
        n = (start >= frame_pixels) ? 0 : frame_pixels - start;   // no wrap past bank end
        if (len < n) n = len;
        for (int i = 0; i < n; i++) bank_model[1 - front_model][start + i] = color;
    endtask

    task automatic send_random_span();
        logic [31:0] r;
        logic [31:0] c;
        r = lcg_next();
        c = lcg_next();
        send_span(coord_t'(r[19:16]), coord_t'(r[26:24]), c[23:0], 1 + int'(r[13:8]) % 40);
    endtask

    // pulse right after frame_start so the very next frame is the new bank
    task automatic do_swap();
        while (busy) tick();
        while (!video.frame_start) tick();
        swap_req = 1'b1;
        tick();
        swap_req = 1'b0;
        front_model = 1 - front_model;
    endtask

    task automatic check_frame();
        int   h;
        int   v;
        int   n_de;
        int   n_fs;
        logic exp_de;
        n_de = 0;
        n_fs = 0;
        while (!video.frame_start) tick();
        for (int k = 0; k < h_total * v_total; k++) begin
            h = k % h_total;
            v = k / h_total;
            exp_de = (h < h_disp) && (v < v_disp);
            compare_count("video.de", int'(video.de), int'(exp_de));
            compare_count("video.hsync", int'(video.hsync),
                          int'(h >= h_sync_start && h < h_sync_start + h_sync_len));
            compare_count("video.vsync", int'(video.vsync),
                          int'(v >= v_sync_start && v < v_sync_start + v_sync_len));
            if (exp_de) begin
                compare_pixel("video.pixel", video.pixel, bank_model[front_model][v * h_disp + h]);
            end else begin
                compare_pixel("video.pixel", video.pixel, '0);   // black in blanking
            end
            n_de += int'(video.de);
            n_fs += int'(video.frame_start);
            tick();
        end
        compare_count("de pixels per frame", n_de, h_disp * v_disp);
        compare_count("frame_start per frame", n_fs, 1);
    endtask

    task automatic fill_test();
        send_span(5'd0, 5'd0, pixel_t'(lcg_next() >> 8), 128);
        do_swap();
        check_frame();
        send_span(5'd0, 5'd0, pixel_t'(lcg_next() >> 8), 128);   // the other bank
        do_swap();
        check_frame();
    endtask

    task automatic random_span_test();
        fork
            begin
                for (int i = 0; i < 20; i++) send_random_span();
            end
            begin
                check_frame();   // front must not move while back is written
                check_frame();
            end
        join
        do_swap();
        check_frame();
    endtask

    task automatic clip_test();
        send_span(5'd10, 5'd7, pixel_t'(lcg_next() >> 8), 200);   // only 6 pixels fit
        do_swap();
        check_frame();
    endtask

    task automatic backpressure_test();
        send_span(5'd0, 5'd2, pixel_t'(lcg_next() >> 8), 30);
        send_span(5'd3, 5'd4, pixel_t'(lcg_next() >> 8), 12);   // held while busy
        send_span(5'd5, 5'd1, pixel_t'(lcg_next() >> 8), 0);
        send_span(5'd0, 5'd6, pixel_t'(lcg_next() >> 8), 9);
        do_swap();
        check_frame();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        span          = '0;
        span_valid    = 1'b0;
        swap_req      = 1'b0;
        front_model   = 0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        cycle_cnt     = 0;
        accept_cnt    = 0;
        spans_sent    = 0;
        busy_prev     = 1'b0;
        lcg_state     = 32'd51086;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < frame_pixels; i++) bank_model[b][i] = '0;
        end
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        compare_count("busy", int'(busy), 0);
        compare_count("video.de", int'(video.de), 0);
        compare_count("video.frame_start", int'(video.frame_start), 0);
        fill_test();
        random_span_test();
        clip_test();
        backpressure_test();
        compare_count("accepted spans", accept_cnt, spans_sent);
        $display("%0d value mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/fb_display.sv */
`timescale 1ns/1ps

module fb_display (
    input  logic              clk,
    input  logic              rst_n,
    input  fb_pkg::span_t     span,
    input  logic              span_valid,
    output logic              busy,
    input  logic              swap_req,
    output video_pkg::video_t video
);

    import video_pkg::*;
    import fb_pkg::*;

    logic     front_bank;   // scan-out owns it, writer avoids it
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    fb_addr_t rd_addr;
    pixel_t   rd_data;

    span_writer u_span_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .span       (span),
        .span_valid (span_valid),
        .busy       (busy),
        .front_bank (front_bank),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

    frame_ram u_frame_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    scan_out u_scan_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .swap_req   (swap_req),
        .front_bank (front_bank),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .video      (video)
    );

endmodule

/* hdl/scan_out.sv */
`timescale 1ns/1ps

module scan_out (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              swap_req,
    output logic              front_bank,
    output fb_pkg::fb_addr_t  rd_addr,
    input  video_pkg::pixel_t rd_data,
    output video_pkg::video_t video
);

    import video_pkg::*;
    import fb_pkg::*;

    // timing flags that travel alongside the pixel read
    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
        logic frame_start;
    } flags_t;

    coord_t     hcount;
    coord_t     vcount;
    logic       h_last;
    logic       wrap;          // last pixel of the last line
    logic       swap_pending;
    flags_t     flags0;        // from the counters
    flags_t     flags1;        // aligned with rd_data
    line_addr_t line_idx;

    assign h_last = (hcount == coord_t'(h_total - 1));
    assign wrap   = h_last && (vcount == coord_t'(v_total - 1));

    // raster counters, free running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_last) begin
                hcount <= '0;
                vcount <= wrap ? '0 : vcount + coord_t'(1);
            end else begin
                hcount <= hcount + coord_t'(1);
            end
        end
    end

    // swap is only applied at the frame boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            front_bank   <= 1'b0;
            swap_pending <= 1'b0;
        end else if (wrap) begin
            front_bank   <= front_bank ^ swap_pending;
            swap_pending <= swap_req;
        end else if (swap_req) begin
            swap_pending <= 1'b1;
        end
    end

    always_comb begin
        flags0.de = (hcount < coord_t'(h_disp)) && (vcount < coord_t'(v_disp));
        flags0.hsync = (hcount >= coord_t'(h_sync_start)) &&
                       (hcount < coord_t'(h_sync_start + h_sync_len));
        flags0.vsync = (vcount >= coord_t'(v_sync_start)) &&
                       (vcount < coord_t'(v_sync_start + v_sync_len));
        flags0.frame_start = (hcount == '0) && (vcount == '0);
    end

    // address is don't-care in blanking, truncation is harmless there
    assign line_idx = line_addr_t'(vcount * h_disp + hcount);
    assign rd_addr  = '{bank: front_bank, idx: line_idx};

    // stage 1 waits for the memory, stage 2 is the output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags1 <= '0;
            video  <= '0;
        end else begin
            flags1            <= flags0;
            video.pixel       <= flags1.de ? rd_data : '0;   // black in blanking
            video.de          <= flags1.de;
            video.hsync       <= flags1.hsync;
            video.vsync       <= flags1.vsync;
            video.frame_start <= flags1.frame_start;
        end
    end

    a_no_de_in_vsync: assert property (@(posedge clk) disable iff (!rst_n)
        !(video.de && video.vsync));

endmodule

/* hdl/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram (
    input  logic              clk,
    input  logic              rst_n,
    input  fb_pkg::wb_req_t   wb_req,
    output fb_pkg::wb_rsp_t   wb_rsp,
    input  fb_pkg::fb_addr_t  rd_addr,
    output video_pkg::pixel_t rd_data
);

    import video_pkg::*;
    import fb_pkg::*;

    // both banks in one array with the bank bit as address msb
    pixel_t mem [fb_words];

    logic ack;
    logic wr_en;

    // one write per stb
    // the held stb in the ack cycle writes nothing
    assign wr_en = wb_req.cyc && wb_req.stb && wb_req.we && !ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= wb_req.cyc && wb_req.stb && !ack;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wb_req.adr] <= wb_req.dat;
        end
    end

    // raster read port with one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    assign wb_rsp.ack = ack;

    // ack answers a request the master still holds at the same address
    a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> ($past(wb_req.stb) && wb_req.stb && $stable(wb_req.adr)));

endmodule

/* hdl/span_writer.sv */
`timescale 1ns/1ps

module span_writer (
    input  logic            clk,
    input  logic            rst_n,
    input  fb_pkg::span_t   span,
    input  logic            span_valid,
    output logic            busy,
    input  logic            front_bank,
    output fb_pkg::wb_req_t wb_req,
    input  fb_pkg::wb_rsp_t wb_rsp
);

    import video_pkg::*;
    import fb_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_strobe,   // first cycle of stb
        s_wait,     // stb held until ack
        s_gap       // stb low one cycle after ack
    } state_t;

    state_t     state;
    logic [9:0] start_lin;  // may exceed a bank for large x/y
    logic [7:0] room;       // pixels left from start to end of bank
    logic [7:0] clip_len;
    logic       accept;

    logic [7:0] idx;        // one bit wider than line_addr_t
    logic [7:0] cnt;        // pixels still to write incl. the current one
    logic       bank;
    pixel_t     color;

    assign accept = span_valid && (state == s_idle);

    // clip the span against the end of the bank without wrap
    always_comb begin
        start_lin = 10'(span.y) * 10'(h_disp) + 10'(span.x);
        if (start_lin >= 10'(frame_pixels)) begin
            room = '0;
        end else begin
            room = 8'(10'(frame_pixels) - start_lin);
        end
        clip_len = (span.len < room) ? span.len : room;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            idx   <= '0;
            cnt   <= '0;
            bank  <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (accept) begin
                        idx  <= start_lin[7:0];
                        cnt  <= clip_len;
                        bank <= ~front_bank;   // write the back half
                        // len 0 still spends one busy cycle in gap
                        state <= (clip_len == '0) ? s_gap : s_strobe;
                    end
                end
                s_strobe: state <= s_wait;
                s_wait: begin
                    if (wb_rsp.ack) begin
                        if (cnt == 8'd1) begin
                            state <= s_idle;
                        end else begin
                            state <= s_gap;
                        end
                        cnt <= cnt - 8'd1;
                        idx <= idx + 8'd1;
                    end
                end
                s_gap: state <= (cnt == '0) ? s_idle : s_strobe;
                default: state <= s_idle;
            endcase
        end
    end

    // colour of the span being written
    always_ff @(posedge clk) begin
        if (accept) color <= span.color;
    end

    assign busy = (state != s_idle);

    always_comb begin
        wb_req.cyc     = busy;
        wb_req.stb     = (state == s_strobe) || (state == s_wait);
        wb_req.we      = busy;
        wb_req.adr.bank = bank;
        wb_req.adr.idx = line_addr_t'(idx);
        wb_req.dat     = color;
    end

    // request held unchanged until the slave acks
    a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)));

    // clip must keep every write inside the bank
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> (idx < 8'(frame_pixels)));

endmodule

/* hdl/fb_pkg.sv */
package fb_pkg;

    // pixels per bank
    localparam int frame_pixels = 128;
    // two banks, ping and pong
    localparam int fb_words = 2 * frame_pixels;

    // linear index inside one bank, y * h_disp + x
    typedef logic [6:0] line_addr_t;

    // full memory address, bank bit on top
    typedef struct packed {
        logic       bank;
        line_addr_t idx;
    } fb_addr_t;

    // host span command
    // paint len pixels from linear index y * h_disp + x onward
    typedef struct packed {
        video_pkg::coord_t x;
        video_pkg::coord_t y;
        video_pkg::pixel_t color;
        logic [7:0]        len;
    } span_t;

    // wishbone classic, master side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        fb_addr_t          adr;
        video_pkg::pixel_t dat;
    } wb_req_t;

    // wishbone classic, slave side
    typedef struct packed {
        logic ack;
    } wb_rsp_t;

endpackage

/* hdl/video_pkg.sv */
package video_pkg;

    // visible area, kept tiny for short simulation
    localparam int h_disp = 16;
    localparam int v_disp = 8;

    // totals incl. blanking
    localparam int h_total = 20;   // 4 pixels of horizontal blanking
    localparam int v_total = 10;   // 2 lines of vertical blanking

    // sync placement within line / frame
    localparam int h_sync_start = 17;
    localparam int h_sync_len = 2;
    localparam int v_sync_start = 8;
    localparam int v_sync_len = 1;

    // 8 bits each of r, g, b
    typedef logic [23:0] pixel_t;

    // wide enough for h_total and for any span start column/row
    typedef logic [4:0] coord_t;

    // parallel video stream, all fields aligned to the same cycle
    typedef struct packed {
        pixel_t pixel;
        logic   de;
        logic   hsync;
        logic   vsync;
        logic   frame_start;   // with first visible pixel
    } video_t;

endpackage
